// File: source/axi_perf_defs.svh
`ifndef AXI_PERF_DEFS_SVH
`define AXI_PERF_DEFS_SVH

// merged write port
`define AXI_ADDR_WIDTH 20
`define AXI_DATA_WIDTH 16
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)
`define AXI_ID_WIDTH 4
`define AXI_SIZE_FULL ($clog2(`AXI_STRB_WIDTH))
`define AXI_BURST_INCR 2'b01

// traffic generators
`define NUM_GEN 2
`define GEN_ID_WIDTH 3
`define SRC_WIDTH (`AXI_ID_WIDTH - `GEN_ID_WIDTH)
`define BEATS_WIDTH 8
`define COUNT_WIDTH 16

`define STAT_WIDTH 32

`endif

// File: source/axi_perf_pkg.sv
package axi_perf_pkg;

`include "axi_perf_defs.svh"

  typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
  typedef logic [`AXI_STRB_WIDTH-1:0] strb_t;
  typedef logic [`AXI_ID_WIDTH-1:0] id_t;
  typedef logic [`GEN_ID_WIDTH-1:0] gen_id_t;

  // burst length minus one, as on awlen
  typedef logic [`BEATS_WIDTH-1:0] beats_t;
  typedef logic [`COUNT_WIDTH-1:0] count_t;
  typedef logic [`STAT_WIDTH-1:0] stat_t;

  typedef enum logic [1:0] {
    PERF_IDLE,
    PERF_RUN,
    PERF_WAIT,
    PERF_REPORT
  } perf_state_e;

  // addr while bursts remain to issue, data until the last wlast
  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_ADDR,
    GEN_DATA,
    GEN_DRAIN
  } gen_state_e;

endpackage

// File: source/axi_perf_wr.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf_wr (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  axi_perf_pkg::addr_t   base_addr,
  input  axi_perf_pkg::beats_t  burst_len,
  input  axi_perf_pkg::addr_t   burst_stride,
  input  axi_perf_pkg::count_t  burst_num,
  output logic                  busy,
  output logic                  m_axi_awvalid,
  output axi_perf_pkg::addr_t   m_axi_awaddr,
  output axi_perf_pkg::gen_id_t m_axi_awid,
  output axi_perf_pkg::beats_t  m_axi_awlen,
  output logic [2:0]            m_axi_awsize,
  output logic [1:0]            m_axi_awburst,
  input  logic                  m_axi_awready,
  output logic                  m_axi_wvalid,
  output axi_perf_pkg::data_t   m_axi_wdata,
  output axi_perf_pkg::strb_t   m_axi_wstrb,
  output logic                  m_axi_wlast,
  input  logic                  m_axi_wready,
  input  logic                  m_axi_bvalid,
  input  axi_perf_pkg::gen_id_t m_axi_bid,
  input  logic [1:0]            m_axi_bresp,
  output logic                  m_axi_bready
);
  import axi_perf_pkg::*;

  localparam int MAX_OUTSTANDING = 2;
  localparam int NUM_IDS = 1 << `GEN_ID_WIDTH;

  gen_state_e state;
  count_t aw_cnt;
  count_t w_cnt;
  count_t b_cnt;
  count_t aw_cnt_nxt;
  count_t b_cnt_nxt;
  count_t in_flight;
  addr_t w_base;
  addr_t w_addr;
  beats_t w_beat;
  logic [NUM_IDS-1:0] id_pend;
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic w_done;

  assign aw_hs = m_axi_awvalid && m_axi_awready;
  assign w_hs = m_axi_wvalid && m_axi_wready;
  assign b_hs = m_axi_bvalid && m_axi_bready;
  assign w_done = w_hs && m_axi_wlast;

  assign aw_cnt_nxt = aw_cnt + count_t'(aw_hs);
  assign b_cnt_nxt = b_cnt + count_t'(b_hs);
  assign in_flight = aw_cnt_nxt - b_cnt_nxt;

  assign busy = state != GEN_IDLE;

  // each burst gets the next id, ids in flight never collide
  assign m_axi_awid = gen_id_t'(aw_cnt);
  assign m_axi_awlen = burst_len;
  assign m_axi_awsize = 3'(`AXI_SIZE_FULL);
  assign m_axi_awburst = `AXI_BURST_INCR;

  // data only for bursts whose address went out
  assign m_axi_wvalid = w_cnt != aw_cnt;
  assign m_axi_wdata = data_t'(w_addr);
  assign m_axi_wstrb = '1;
  assign m_axi_wlast = w_beat == burst_len;

  // accept responses only for ids still open
  assign m_axi_bready = id_pend[m_axi_bid];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= GEN_IDLE;
      m_axi_awvalid <= 1'b0;
      aw_cnt <= '0;
      w_cnt <= '0;
      b_cnt <= '0;
      id_pend <= '0;
    end else begin
      aw_cnt <= aw_cnt_nxt;
      b_cnt <= b_cnt_nxt;
      if (w_done) begin
        w_cnt <= w_cnt + 1'b1;
      end
      if (b_hs) begin
        id_pend[m_axi_bid] <= 1'b0;
      end
      if (aw_hs) begin
        id_pend[m_axi_awid] <= 1'b1;
      end

      case (state)
        GEN_IDLE: begin
          if (start) begin
            state <= (burst_num != '0) ? GEN_ADDR : GEN_IDLE;
            m_axi_awvalid <= burst_num != '0;
            aw_cnt <= '0;
            w_cnt <= '0;
            b_cnt <= '0;
          end
        end
        GEN_ADDR: begin
          // address phase runs ahead by at most two unanswered bursts
          m_axi_awvalid <= (aw_cnt_nxt != burst_num) && (in_flight < count_t'(MAX_OUTSTANDING));
          if (aw_cnt_nxt == burst_num) begin
            state <= GEN_DATA;
          end
        end
        GEN_DATA: begin
          if (w_done && (w_cnt + 1'b1) == burst_num) begin
            state <= GEN_DRAIN;
          end
        end
        GEN_DRAIN: begin
          // idle once every response is back
          if (b_cnt == burst_num) begin
            state <= GEN_IDLE;
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  // burst and beat addresses
  always_ff @(posedge clk) begin
    if (state == GEN_IDLE && start) begin
      m_axi_awaddr <= base_addr;
      w_base <= base_addr;
      w_addr <= base_addr;
      w_beat <= '0;
    end else begin
      if (aw_hs) begin
        m_axi_awaddr <= m_axi_awaddr + burst_stride;
      end
      if (w_hs && m_axi_wlast) begin
        w_base <= w_base + burst_stride;
        w_addr <= w_base + burst_stride;
        w_beat <= '0;
      end else if (w_hs) begin
        w_addr <= w_addr + addr_t'(`AXI_STRB_WIDTH);
        w_beat <= w_beat + 1'b1;
      end
    end
  end

endmodule

// File: source/axi_wr_arbiter.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_wr_arbiter (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`NUM_GEN-1:0]                   s_axi_awvalid,
  input  axi_perf_pkg::addr_t   [`NUM_GEN-1:0]  s_axi_awaddr,
  input  axi_perf_pkg::gen_id_t [`NUM_GEN-1:0]  s_axi_awid,
  input  axi_perf_pkg::beats_t  [`NUM_GEN-1:0]  s_axi_awlen,
  input  logic [`NUM_GEN-1:0][2:0]              s_axi_awsize,
  input  logic [`NUM_GEN-1:0][1:0]              s_axi_awburst,
  output logic [`NUM_GEN-1:0]                   s_axi_awready,
  input  logic [`NUM_GEN-1:0]                   s_axi_wvalid,
  input  axi_perf_pkg::data_t   [`NUM_GEN-1:0]  s_axi_wdata,
  input  axi_perf_pkg::strb_t   [`NUM_GEN-1:0]  s_axi_wstrb,
  input  logic [`NUM_GEN-1:0]                   s_axi_wlast,
  output logic [`NUM_GEN-1:0]                   s_axi_wready,
  output logic [`NUM_GEN-1:0]                   s_axi_bvalid,
  output axi_perf_pkg::gen_id_t [`NUM_GEN-1:0]  s_axi_bid,
  output logic [`NUM_GEN-1:0][1:0]              s_axi_bresp,
  input  logic [`NUM_GEN-1:0]                   s_axi_bready,
  output logic                                  m_axi_awvalid,
  output axi_perf_pkg::addr_t                   m_axi_awaddr,
  output axi_perf_pkg::id_t                     m_axi_awid,
  output axi_perf_pkg::beats_t                  m_axi_awlen,
  output logic [2:0]                            m_axi_awsize,
  output logic [1:0]                            m_axi_awburst,
  input  logic                                  m_axi_awready,
  output logic                                  m_axi_wvalid,
  output axi_perf_pkg::data_t                   m_axi_wdata,
  output axi_perf_pkg::strb_t                   m_axi_wstrb,
  output logic                                  m_axi_wlast,
  input  logic                                  m_axi_wready,
  input  logic                                  m_axi_bvalid,
  input  axi_perf_pkg::id_t                     m_axi_bid,
  input  logic [1:0]                            m_axi_bresp,
  output logic                                  m_axi_bready
);
  import axi_perf_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int SRC_W = `SRC_WIDTH;

  logic [SRC_W-1:0] aw_src;
  logic [SRC_W-1:0] aw_cand;
  logic [SRC_W-1:0] last_src;
  logic [SRC_W-1:0] lock_src;
  logic [SRC_W-1:0] w_src;
  logic [SRC_W-1:0] b_src;
  logic locked;
  logic aw_hs;
  logic w_done;

  // write order queue, one source index per granted burst
  logic [SRC_W-1:0] order_q[QUEUE_DEPTH];
  logic [1:0] q_wr_ptr;
  logic [1:0] q_rd_ptr;
  logic [2:0] q_count;
  logic q_full;
  logic q_empty;

  // first valid source after the last grant wins
  always_comb begin
    aw_src = last_src;
    aw_cand = last_src;
    for (int k = `NUM_GEN; k >= 1; k--) begin
      aw_cand = last_src + SRC_W'(k);
      if (s_axi_awvalid[aw_cand]) begin
        aw_src = aw_cand;
      end
    end
    // hold the grant while the port waits for awready
    if (locked) begin
      aw_src = lock_src;
    end
  end

  assign q_full = q_count == 3'(QUEUE_DEPTH);
  assign q_empty = q_count == '0;

  assign m_axi_awvalid = s_axi_awvalid[aw_src] && !q_full;
  assign m_axi_awaddr = s_axi_awaddr[aw_src];
  assign m_axi_awid = {aw_src, s_axi_awid[aw_src]};
  assign m_axi_awlen = s_axi_awlen[aw_src];
  assign m_axi_awsize = s_axi_awsize[aw_src];
  assign m_axi_awburst = s_axi_awburst[aw_src];
  assign aw_hs = m_axi_awvalid && m_axi_awready;

  always_comb begin
    s_axi_awready = '0;
    s_axi_awready[aw_src] = m_axi_awready && !q_full;
  end

  // w follows the head of the order queue until wlast
  assign w_src = order_q[q_rd_ptr];
  assign m_axi_wvalid = !q_empty && s_axi_wvalid[w_src];
  assign m_axi_wdata = s_axi_wdata[w_src];
  assign m_axi_wstrb = s_axi_wstrb[w_src];
  assign m_axi_wlast = s_axi_wlast[w_src];
  assign w_done = m_axi_wvalid && m_axi_wready && m_axi_wlast;

  always_comb begin
    s_axi_wready = '0;
    s_axi_wready[w_src] = m_axi_wready && !q_empty;
  end

  // top id bits name the source
  assign b_src = m_axi_bid[`AXI_ID_WIDTH-1 -: SRC_W];
  assign m_axi_bready = s_axi_bready[b_src];
  assign s_axi_bid = {`NUM_GEN{m_axi_bid[`GEN_ID_WIDTH-1:0]}};
  assign s_axi_bresp = {`NUM_GEN{m_axi_bresp}};

  always_comb begin
    s_axi_bvalid = '0;
    s_axi_bvalid[b_src] = m_axi_bvalid;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      locked <= 1'b0;
      last_src <= '0;
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      q_count <= '0;
    end else begin
      locked <= m_axi_awvalid && !m_axi_awready;
      if (aw_hs) begin
        last_src <= aw_src;
        q_wr_ptr <= q_wr_ptr + 1'b1;
      end
      if (w_done) begin
        q_rd_ptr <= q_rd_ptr + 1'b1;
      end
      q_count <= q_count + 3'(aw_hs) - 3'(w_done);
    end
  end

  always_ff @(posedge clk) begin
    if (m_axi_awvalid) begin
      lock_src <= aw_src;
    end
    if (aw_hs) begin
      order_q[q_wr_ptr] <= aw_src;
    end
  end

endmodule

// File: source/axi_wr_stats.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_wr_stats (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 clear,
  input  logic                 m_axi_awvalid,
  input  logic                 m_axi_awready,
  input  axi_perf_pkg::beats_t m_axi_awlen,
  input  logic                 m_axi_wvalid,
  input  logic                 m_axi_wready,
  input  logic                 m_axi_bvalid,
  input  logic                 m_axi_bready,
  input  logic [1:0]           m_axi_bresp,
  output axi_perf_pkg::stat_t  bursts,
  output axi_perf_pkg::stat_t  beats,
  output axi_perf_pkg::stat_t  bytes,
  output axi_perf_pkg::stat_t  errors,
  output axi_perf_pkg::stat_t  cycles
);
  import axi_perf_pkg::*;

  stat_t pend_bursts;
  stat_t owed_beats;
  stat_t aw_beats;
  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic active;

  assign aw_hs = m_axi_awvalid && m_axi_awready;
  assign w_hs = m_axi_wvalid && m_axi_wready;
  assign b_hs = m_axi_bvalid && m_axi_bready;
  assign aw_beats = aw_hs ? stat_t'(m_axi_awlen) + 1'b1 : '0;

  // busy while an address waits, data is owed or a response is open
  assign active = m_axi_awvalid || pend_bursts != '0 || owed_beats != '0;

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      bursts <= '0;
      beats <= '0;
      bytes <= '0;
      errors <= '0;
      cycles <= '0;
      pend_bursts <= '0;
      owed_beats <= '0;
    end else begin
      if (aw_hs) begin
        bursts <= bursts + 1'b1;
      end
      if (w_hs) begin
        beats <= beats + 1'b1;
        bytes <= bytes + stat_t'(`AXI_STRB_WIDTH);
      end
      // slverr and decerr alike
      if (b_hs && m_axi_bresp != 2'b00) begin
        errors <= errors + 1'b1;
      end
      if (active) begin
        cycles <= cycles + 1'b1;
      end
      pend_bursts <= pend_bursts + stat_t'(aw_hs) - stat_t'(b_hs);
      owed_beats <= owed_beats + aw_beats - stat_t'(w_hs);
    end
  end

endmodule

// File: source/axi_perf.sv
`timescale 1ns/1ps
`include "axi_perf_defs.svh"

module axi_perf (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  axi_perf_pkg::addr_t  cmd_base_addr0,
  input  axi_perf_pkg::addr_t  cmd_base_addr1,
  input  axi_perf_pkg::beats_t cmd_len,
  input  axi_perf_pkg::addr_t  cmd_stride,
  input  axi_perf_pkg::count_t cmd_bursts,
  output logic                 res_valid,
  input  logic                 res_ready,
  output axi_perf_pkg::stat_t  res_bursts,
  output axi_perf_pkg::stat_t  res_beats,
  output axi_perf_pkg::stat_t  res_bytes,
  output axi_perf_pkg::stat_t  res_errors,
  output axi_perf_pkg::stat_t  res_cycles,
  output logic                 m_axi_awvalid,
  output axi_perf_pkg::addr_t  m_axi_awaddr,
  output axi_perf_pkg::id_t    m_axi_awid,
  output axi_perf_pkg::beats_t m_axi_awlen,
  output logic [2:0]           m_axi_awsize,
  output logic [1:0]           m_axi_awburst,
  input  logic                 m_axi_awready,
  output logic                 m_axi_wvalid,
  output axi_perf_pkg::data_t  m_axi_wdata,
  output axi_perf_pkg::strb_t  m_axi_wstrb,
  output logic                 m_axi_wlast,
  input  logic                 m_axi_wready,
  input  logic                 m_axi_bvalid,
  input  axi_perf_pkg::id_t    m_axi_bid,
  input  logic [1:0]           m_axi_bresp,
  output logic                 m_axi_bready
);
  import axi_perf_pkg::*;

  perf_state_e state;
  logic accept;
  logic start;
  logic [`NUM_GEN-1:0] gen_busy;

  addr_t [`NUM_GEN-1:0] cfg_base;
  beats_t cfg_len;
  addr_t cfg_stride;
  count_t cfg_bursts;

  // generator side of the arbiter
  logic [`NUM_GEN-1:0] s_axi_awvalid;
  addr_t [`NUM_GEN-1:0] s_axi_awaddr;
  gen_id_t [`NUM_GEN-1:0] s_axi_awid;
  beats_t [`NUM_GEN-1:0] s_axi_awlen;
  logic [`NUM_GEN-1:0][2:0] s_axi_awsize;
  logic [`NUM_GEN-1:0][1:0] s_axi_awburst;
  logic [`NUM_GEN-1:0] s_axi_awready;
  logic [`NUM_GEN-1:0] s_axi_wvalid;
  data_t [`NUM_GEN-1:0] s_axi_wdata;
  strb_t [`NUM_GEN-1:0] s_axi_wstrb;
  logic [`NUM_GEN-1:0] s_axi_wlast;
  logic [`NUM_GEN-1:0] s_axi_wready;
  logic [`NUM_GEN-1:0] s_axi_bvalid;
  gen_id_t [`NUM_GEN-1:0] s_axi_bid;
  logic [`NUM_GEN-1:0][1:0] s_axi_bresp;
  logic [`NUM_GEN-1:0] s_axi_bready;

  assign cmd_ready = state == PERF_IDLE;
  assign accept = cmd_valid && cmd_ready;
  assign start = state == PERF_RUN;
  assign res_valid = state == PERF_REPORT;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= PERF_IDLE;
    end else begin
      case (state)
        PERF_IDLE: begin
          if (accept) begin
            state <= PERF_RUN;
          end
        end
        PERF_RUN: state <= PERF_WAIT;
        PERF_WAIT: begin
          if (gen_busy == '0) begin
            state <= PERF_REPORT;
          end
        end
        PERF_REPORT: begin
          if (res_ready) begin
            state <= PERF_IDLE;
          end
        end
        default: state <= PERF_IDLE;
      endcase
    end
  end

  // command held for the whole run
  always_ff @(posedge clk) begin
    if (accept) begin
      cfg_base[0] <= cmd_base_addr0;
      cfg_base[1] <= cmd_base_addr1;
      cfg_len <= cmd_len;
      cfg_stride <= cmd_stride;
      cfg_bursts <= cmd_bursts;
    end
  end

  for (genvar i = 0; i < `NUM_GEN; i++) begin : gen_wr
    axi_perf_wr i_wr (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .base_addr    (cfg_base[i]),
      .burst_len    (cfg_len),
      .burst_stride (cfg_stride),
      .burst_num    (cfg_bursts),
      .busy         (gen_busy[i]),
      .m_axi_awvalid(s_axi_awvalid[i]),
      .m_axi_awaddr (s_axi_awaddr[i]),
      .m_axi_awid   (s_axi_awid[i]),
      .m_axi_awlen  (s_axi_awlen[i]),
      .m_axi_awsize (s_axi_awsize[i]),
      .m_axi_awburst(s_axi_awburst[i]),
      .m_axi_awready(s_axi_awready[i]),
      .m_axi_wvalid (s_axi_wvalid[i]),
      .m_axi_wdata  (s_axi_wdata[i]),
      .m_axi_wstrb  (s_axi_wstrb[i]),
      .m_axi_wlast  (s_axi_wlast[i]),
      .m_axi_wready (s_axi_wready[i]),
      .m_axi_bvalid (s_axi_bvalid[i]),
      .m_axi_bid    (s_axi_bid[i]),
      .m_axi_bresp  (s_axi_bresp[i]),
      .m_axi_bready (s_axi_bready[i])
    );
  end

  // port names match on both sides
  axi_wr_arbiter i_arbiter (.*);

  // only watches the merged port
  axi_wr_stats i_stats (
    .clear (accept),
    .bursts(res_bursts),
    .beats (res_beats),
    .bytes (res_bytes),
    .errors(res_errors),
    .cycles(res_cycles),
    .*
  );

endmodule

// File: tb/axi_perf_chk.sv
`timescale 1ns/1ps

module axi_perf_chk (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 m_axi_awvalid,
  input logic                 m_axi_awready,
  input axi_perf_pkg::addr_t  m_axi_awaddr,
  input axi_perf_pkg::id_t    m_axi_awid,
  input logic                 m_axi_wvalid,
  input logic                 m_axi_wready,
  input axi_perf_pkg::data_t  m_axi_wdata,
  input logic                 m_axi_wlast,
  input logic                 res_valid,
  input logic                 res_ready,
  input axi_perf_pkg::stat_t  res_beats
);
  import axi_perf_pkg::*;

  // bursts granted but not fully written, bounded by the order queue
  int unsigned open_bursts;
  // failed assertions so far
  int unsigned fail_count;

  initial begin
    fail_count = 0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      open_bursts <= 0;
    end else begin
      open_bursts <= open_bursts + ((m_axi_awvalid && m_axi_awready) ? 1 : 0)
        - ((m_axi_wvalid && m_axi_wready && m_axi_wlast) ? 1 : 0);
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_axi_awvalid && !m_axi_awready |=>
      m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awid))
    else begin
      $error("aw channel changed before awready");
      fail_count++;
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_axi_wvalid && !m_axi_wready |=> m_axi_wvalid && $stable(m_axi_wdata))
    else begin
      $error("w channel changed before wready");
      fail_count++;
    end

  res_hold: assert property (@(posedge clk) disable iff (!rst_n)
    res_valid && !res_ready |=> res_valid && $stable(res_beats))
    else begin
      $error("result changed before res_ready");
      fail_count++;
    end

  queue_limit: assert property (@(posedge clk) disable iff (!rst_n) open_bursts <= 4)
    else begin
      $error("more than four bursts waiting for data");
      fail_count++;
    end

endmodule

// File: tb/axi_perf_monitor.sv
`timescale 1ns/1ps

module axi_perf_monitor (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  input  logic                 cmd_ready,
  input  axi_perf_pkg::addr_t  cmd_base_addr0,
  input  axi_perf_pkg::addr_t  cmd_base_addr1,
  input  axi_perf_pkg::beats_t cmd_len,
  input  axi_perf_pkg::addr_t  cmd_stride,
  input  axi_perf_pkg::count_t cmd_bursts,
  input  axi_perf_pkg::addr_t  err_addr,
  input  axi_perf_pkg::stat_t  exp_bursts,
  input  axi_perf_pkg::stat_t  exp_beats,
  input  axi_perf_pkg::stat_t  exp_errors,
  input  logic                 res_valid,
  input  logic                 res_ready,
  input  axi_perf_pkg::stat_t  res_bursts,
  input  axi_perf_pkg::stat_t  res_beats,
  input  axi_perf_pkg::stat_t  res_bytes,
  input  axi_perf_pkg::stat_t  res_errors,
  input  axi_perf_pkg::stat_t  res_cycles,
  input  logic                 m_axi_awvalid,
  input  logic                 m_axi_awready,
  input  axi_perf_pkg::addr_t  m_axi_awaddr,
  input  axi_perf_pkg::id_t    m_axi_awid,
  input  axi_perf_pkg::beats_t m_axi_awlen,
  input  logic [2:0]           m_axi_awsize,
  input  logic [1:0]           m_axi_awburst,
  input  logic                 m_axi_wvalid,
  input  logic                 m_axi_wready,
  input  axi_perf_pkg::data_t  m_axi_wdata,
  input  axi_perf_pkg::strb_t  m_axi_wstrb,
  input  logic                 m_axi_wlast,
  input  logic                 m_axi_bvalid,
  input  logic                 m_axi_bready,
  input  axi_perf_pkg::id_t    m_axi_bid,
  output int                   error_count,
  output int                   test_count,
  output int                   failed_tests
);
  import axi_perf_pkg::*;

  addr_t base[2];
  addr_t next_k[2];
  int outstanding[2];
  addr_t stride;
  beats_t len;
  count_t nbursts;
  addr_t burst_q[$];
  addr_t beat_addr;
  beats_t beat_idx;
  stat_t err_hits;
  stat_t exp_total;
  stat_t exp_beat_total;
  int test_errs;
  logic running;
  int src;

  task automatic report_mismatch(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    error_count++;
    test_errs++;
  endtask

  initial begin
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    running = 1'b0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (cmd_valid && cmd_ready) begin
        running = 1'b1;
        test_errs = 0;
        base[0] = cmd_base_addr0;
        base[1] = cmd_base_addr1;
        next_k[0] = '0;
        next_k[1] = '0;
        outstanding[0] = 0;
        outstanding[1] = 0;
        stride = cmd_stride;
        len = cmd_len;
        nbursts = cmd_bursts;
        burst_q.delete();
        beat_idx = '0;
        err_hits = '0;
      end else if (running && cmd_ready) begin
        report_mismatch("cmd_ready high while a run is active");
      end

      // expected address per generator follows its own burst index
      if (m_axi_awvalid && m_axi_awready) begin
        src = int'(m_axi_awid[3]);
        if (m_axi_awaddr != addr_t'(base[src] + next_k[src] * stride))
          report_mismatch($sformatf("gen %0d burst %0d awaddr %h", src, next_k[src],
            m_axi_awaddr));
        if (next_k[src] >= addr_t'(nbursts))
          report_mismatch($sformatf("gen %0d issued too many bursts", src));
        if (m_axi_awlen != len)
          report_mismatch($sformatf("awlen %0d, expected %0d", m_axi_awlen, len));
        // two bytes per beat, incrementing bursts
        if (m_axi_awsize != 3'd1)
          report_mismatch($sformatf("awsize %0d, expected 1", m_axi_awsize));
        if (m_axi_awburst != 2'b01)
          report_mismatch($sformatf("awburst %b, expected incr", m_axi_awburst));
        if (m_axi_awaddr == err_addr)
          err_hits = err_hits + 1;
        next_k[src] = next_k[src] + 1'b1;
        outstanding[src]++;
        if (outstanding[src] > 2)
          report_mismatch($sformatf("gen %0d has more than two bursts open", src));
        burst_q.push_back(m_axi_awaddr);
      end

      if (m_axi_wvalid && m_axi_wready) begin
        if (burst_q.size() == 0) begin
          report_mismatch("write beat without a granted burst");
        end else begin
          beat_addr = burst_q[0] + addr_t'(beat_idx) * addr_t'(2);
          if (m_axi_wdata != beat_addr[15:0])
            report_mismatch($sformatf("wdata %h at address %h", m_axi_wdata, beat_addr));
          if (m_axi_wstrb != '1)
            report_mismatch($sformatf("wstrb %b not all ones", m_axi_wstrb));
          if (m_axi_wlast != (beat_idx == len))
            report_mismatch($sformatf("wlast %0d on beat %0d", m_axi_wlast, beat_idx));
          if (m_axi_wlast) begin
            void'(burst_q.pop_front());
            beat_idx = '0;
          end else begin
            beat_idx = beat_idx + 1'b1;
          end
        end
      end

      if (m_axi_bvalid && m_axi_bready) begin
        src = int'(m_axi_bid[3]);
        if (outstanding[src] == 0)
          report_mismatch($sformatf("response to gen %0d with no burst open", src));
        else
          outstanding[src]--;
      end

      if (res_valid && res_ready) begin
        exp_total = stat_t'(nbursts) * 2;
        exp_beat_total = exp_total * (stat_t'(len) + 1);
        if (res_bursts != exp_total || res_bursts != exp_bursts)
          report_mismatch($sformatf("bursts %0d, expected %0d", res_bursts, exp_total));
        if (res_beats != exp_beat_total || res_beats != exp_beats)
          report_mismatch($sformatf("beats %0d, expected %0d", res_beats, exp_beat_total));
        if (res_bytes != exp_beat_total * 2)
          report_mismatch($sformatf("bytes %0d, expected %0d", res_bytes,
            exp_beat_total * 2));
        if (res_errors != err_hits || res_errors != exp_errors)
          report_mismatch($sformatf("errors %0d, expected %0d", res_errors, exp_errors));
        if (res_cycles < res_beats)
          report_mismatch($sformatf("cycles %0d below beats %0d", res_cycles, res_beats));
        if (next_k[0] != addr_t'(nbursts) || next_k[1] != addr_t'(nbursts))
          report_mismatch("result before all bursts were issued");
        if (test_errs == 0) begin
          $display("test %0d: PASS", test_count);
        end else begin
          $display("test %0d: FAIL with %0d errors", test_count, test_errs);
          failed_tests++;
        end
        test_count++;
        running = 1'b0;
      end
    end
  end

endmodule

// File: tb/axi_perf_tb.sv
`timescale 1ns/1ps

module axi_perf_tb;
  import axi_perf_pkg::*;

  localparam int NUM_TESTS = 6;
  localparam int FIELDS = 9;
  localparam int CMD_TIMEOUT = 200;
  localparam int RES_TIMEOUT = 20000;

  logic clk;
  logic rst_n;
  logic cmd_valid;
  logic cmd_ready;
  addr_t cmd_base_addr0;
  addr_t cmd_base_addr1;
  beats_t cmd_len;
  addr_t cmd_stride;
  count_t cmd_bursts;
  logic res_valid;
  logic res_ready;
  stat_t res_bursts;
  stat_t res_beats;
  stat_t res_bytes;
  stat_t res_errors;
  stat_t res_cycles;
  logic m_axi_awvalid;
  addr_t m_axi_awaddr;
  id_t m_axi_awid;
  beats_t m_axi_awlen;
  logic [2:0] m_axi_awsize;
  logic [1:0] m_axi_awburst;
  logic m_axi_awready;
  logic m_axi_wvalid;
  data_t m_axi_wdata;
  strb_t m_axi_wstrb;
  logic m_axi_wlast;
  logic m_axi_wready;
  logic m_axi_bvalid;
  id_t m_axi_bid;
  logic [1:0] m_axi_bresp;
  logic m_axi_bready;

  addr_t err_addr;
  stat_t exp_bursts;
  stat_t exp_beats;
  stat_t exp_errors;
  logic [31:0] vec[NUM_TESTS*FIELDS];
  logic [31:0] rnd_state;
  logic timed_out;
  int error_count;
  int test_count;
  int failed_tests;

  // {id, resp} per burst, in grant order and then in response order
  logic [5:0] aw_q[$];
  logic [5:0] b_q[$];

  axi_perf i_axi_perf (.*);

  axi_perf_monitor i_monitor (.*);

  bind axi_perf axi_perf_chk i_chk (
    .clk(clk), .rst_n(rst_n),
    .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
    .m_axi_awaddr(m_axi_awaddr), .m_axi_awid(m_axi_awid),
    .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
    .m_axi_wdata(m_axi_wdata), .m_axi_wlast(m_axi_wlast),
    .res_valid(res_valid), .res_ready(res_ready), .res_beats(res_beats)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // memory slave with random stalls
  always @(posedge clk) begin : slave
    logic [5:0] entry;
    if (!rst_n) begin
      m_axi_awready <= 1'b0;
      m_axi_wready <= 1'b0;
      m_axi_bvalid <= 1'b0;
      m_axi_bid <= '0;
      m_axi_bresp <= 2'b00;
      aw_q.delete();
      b_q.delete();
    end else begin
      rnd_state = xorshift(rnd_state);
      if (m_axi_awvalid && m_axi_awready)
        aw_q.push_back({m_axi_awid, (m_axi_awaddr == err_addr) ? 2'b10 : 2'b00});
      if (m_axi_wvalid && m_axi_wready && m_axi_wlast && aw_q.size() > 0)
        b_q.push_back(aw_q.pop_front());
      if (m_axi_bvalid && m_axi_bready)
        m_axi_bvalid <= 1'b0;
      if ((!m_axi_bvalid || m_axi_bready) && b_q.size() > 0 && rnd_state[4]) begin
        entry = b_q.pop_front();
        m_axi_bvalid <= 1'b1;
        m_axi_bid <= entry[5:2];
        m_axi_bresp <= entry[1:0];
      end
      m_axi_awready <= rnd_state[0] | rnd_state[1];
      m_axi_wready <= rnd_state[2] | rnd_state[3];
    end
  end

  task automatic wait_accept(output logic ok);
    int cnt;
    cnt = 0;
    @(posedge clk);
    while (!cmd_ready && cnt < CMD_TIMEOUT) begin
      cnt++;
      @(posedge clk);
    end
    ok = cmd_ready;
  endtask

  task automatic wait_result(output logic ok);
    int cnt;
    cnt = 0;
    @(posedge clk);
    while (!res_valid && cnt < RES_TIMEOUT) begin
      cnt++;
      @(posedge clk);
    end
    ok = res_valid;
  endtask

  initial begin : main
    logic ok;
    int base;
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_base_addr0 = '0;
    cmd_base_addr1 = '0;
    cmd_len = '0;
    cmd_stride = '0;
    cmd_bursts = '0;
    res_ready = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready = 1'b0;
    m_axi_bvalid = 1'b0;
    m_axi_bid = '0;
    m_axi_bresp = 2'b00;
    err_addr = '0;
    exp_bursts = '0;
    exp_beats = '0;
    exp_errors = '0;
    rnd_state = 32'h09133823;
    timed_out = 1'b0;
    $readmemh("tb/axi_perf_vectors.txt", vec);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
      base = t * FIELDS;
      @(posedge clk);
      cmd_base_addr0 <= addr_t'(vec[base]);
      cmd_base_addr1 <= addr_t'(vec[base+1]);
      cmd_len <= beats_t'(vec[base+2]);
      cmd_stride <= addr_t'(vec[base+3]);
      cmd_bursts <= count_t'(vec[base+4]);
      err_addr <= addr_t'(vec[base+5]);
      exp_bursts <= vec[base+6];
      exp_beats <= vec[base+7];
      exp_errors <= vec[base+8];
      cmd_valid <= 1'b1;
      wait_accept(ok);
      cmd_valid <= 1'b0;
      if (!ok) begin
        $display("timeout: command of test %0d was never accepted", t);
        timed_out = 1'b1;
      end else begin
        wait_result(ok);
        if (!ok) begin
          $display("timeout: no result for test %0d", t);
          timed_out = 1'b1;
        end else begin
          // result stays held until res_ready
          res_ready <= 1'b1;
          @(posedge clk);
          res_ready <= 1'b0;
        end
      end
    end
    repeat (4) @(posedge clk);
    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
      test_count, failed_tests, error_count, i_axi_perf.i_chk.fail_count);
    if (!timed_out && error_count == 0 && test_count == NUM_TESTS
        && i_axi_perf.i_chk.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tb/axi_perf_vectors.txt
// base0 base1 len stride bursts err_addr exp_bursts exp_beats exp_errors
// all fields hex, one test per line
01000 40000 03 0010 0004 01020 08 20 01
00000 80000 00 0002 0006 fffff 0c 0c 00
0fff0 10000 07 0100 0005 10200 0a 50 01
20000 20000 01 0004 0003 20004 06 0c 02
00100 00200 0f 0020 0001 00100 02 20 01
12345 54321 02 0008 0000 12345 00 00 00

// File: project.f
+incdir+source
source/axi_perf_pkg.sv
source/axi_perf_wr.sv
source/axi_wr_arbiter.sv
source/axi_wr_stats.sv
source/axi_perf.sv
tb/axi_perf_chk.sv
tb/axi_perf_monitor.sv
tb/axi_perf_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module axi_perf_tb \
  -o axi_perf_sim \
  && ./obj_dir/axi_perf_sim | tee /dev/stderr | grep -q "Verification passed" \
  && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }
